// File: list.f
verilog/uart_cfg_pkg.sv
verilog/uart_frame_pkg.sv
verilog/uart_tx_if.sv
verilog/baud_tick_gen.sv
verilog/tx_credit_fifo.sv
verilog/transmitter_controller.sv
verilog/tx_shifter.sv
verilog/uart_tx_top.sv
verif/uart_tx_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f list.f --top-module uart_tx_tb -o uart_tx_sim

out=$(./obj_dir/uart_tx_sim)
echo "$out"

if echo "$out" | grep -qx "TEST PASSED"; then
	exit 0
fi
exit 1

// File: verif/uart_tx_tb.sv
// Testbench for the UART transmit subsystem; random credited writes and CTS holds, line decoded.
`default_nettype none

module uart_tx_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int DATA_BITS      = uart_cfg_pkg::DATA_BITS;
	localparam int CPB            = uart_cfg_pkg::CLKS_PER_BIT;
	localparam int DEPTH          = uart_cfg_pkg::FIFO_DEPTH;
	localparam int NUM_FRAMES     = 40;
	localparam int MAX_FRAME_CLKS = (DATA_BITS + 4) * CPB + 1;
	localparam int MAX_HOLDS      = 6;
	localparam int MAX_HOLD_CLKS  = 64 + 255;
	localparam int DRAIN_CLKS     = (DEPTH + 1) * MAX_FRAME_CLKS + MAX_HOLD_CLKS;
	localparam int TIMEOUT_CLKS   = NUM_FRAMES * MAX_FRAME_CLKS * 2 +
		MAX_HOLDS * (MAX_HOLD_CLKS + MAX_FRAME_CLKS) + 2000;

	logic                        clk;
	logic                        reset_n;
	logic                        tx_en_i;
	logic                        cts_n_i;
	logic                        wr_valid_i;
	uart_frame_pkg::frame_word_t wr_data_i;
	logic                        credit_o;
	logic                        txd_o;
	logic                        tx_finish_o;

	// Words written and not yet seen on the line, oldest first.
	uart_frame_pkg::frame_word_t exp_q[$];

	logic [31:0] rng_state = 32'd75;
	logic        finish_prev = 1'b0;
	int credits = DEPTH;
	int credit_pulses = 0;
	int finish_cnt = 0;
	int frames_done = 0;
	int cyc = 0;
	int cts_low_cyc = 0;
	int err_reset = 0;
	int err_data = 0;
	int err_framing = 0;
	int err_credit = 0;
	int err_cts = 0;
	int err_finish = 0;
	int tests_failed = 0;
	int errors_total = 0;

	uart_tx_top u_uart_tx_top (
		.clk         (clk),
		.reset_n     (reset_n),
		.tx_en_i     (tx_en_i),
		.cts_n_i     (cts_n_i),
		.wr_valid_i  (wr_valid_i),
		.wr_data_i   (wr_data_i),
		.credit_o    (credit_o),
		.txd_o       (txd_o),
		.tx_finish_o (tx_finish_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Last edge at which the DUT saw cts_n_i low.
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (!cts_n_i) begin
			cts_low_cyc <= cyc;
		end
	end

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// Advance to the next falling edge and account credits and finish pulses.
	task automatic next_cycle();
		@(negedge clk);
		if (credit_o) begin
			credits++;
			credit_pulses++;
			assert (credits <= DEPTH) else begin
				$display("credit_o returned a credit that no write had spent");
				err_credit++;
			end
		end
		if (tx_finish_o) begin
			assert (!finish_prev) else begin
				$display("tx_finish_o stayed high for more than one cycle");
				err_finish++;
			end
			finish_cnt++;
		end
		finish_prev = tx_finish_o;
	endtask

	task automatic report_test(input string name, input int errs);
		if (errs == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: failed with %0d errors", name, errs);
			tests_failed++;
		end
		errors_total += errs;
	endtask

	initial begin : stimulus
		uart_frame_pkg::frame_word_t w;
		logic [31:0] r;
		int i;
		int sent;
		int holds;
		int hold_left;
		int waited;

		reset_n    = 1'b0;
		tx_en_i    = 1'b0;
		cts_n_i    = 1'b0;
		wr_valid_i = 1'b0;
		wr_data_i  = '0;
		sent       = 0;
		holds      = 0;
		hold_left  = 0;
		waited     = 0;
		repeat (4) @(negedge clk);
		reset_n = 1'b1;

		// Quiet line, transmitter enabled halfway through.
		for (i = 0; i < 4 * CPB; i++) begin
			next_cycle();
			if (i == 2 * CPB) begin
				tx_en_i = 1'b1;
			end
			assert (txd_o === 1'b1 && credit_o === 1'b0 && tx_finish_o === 1'b0) else begin
				$display("error reset_idle: expected txd/credit/finish 1/0/0, actual %b/%b/%b",
					txd_o, credit_o, tx_finish_o);
				err_reset++;
			end
		end

		while (sent < NUM_FRAMES) begin
			next_cycle();
			wr_valid_i = 1'b0;
			r = lcg_next();
			if (hold_left > 0) begin
				hold_left--;
				if (hold_left == 0) begin
					cts_n_i = 1'b0;
				end
			end else if (holds < MAX_HOLDS && r[30:21] < 10'd3) begin
				cts_n_i   = 1'b1;
				hold_left = 64 + int'(r[20:13]);
				holds++;
			end
			r = lcg_next();
			if (credits > 0 && r[30:27] < 4'd6) begin
				w.data       = r[23:16];
				w.parity_en  = r[24];
				w.parity_odd = r[25];
				w.two_stop   = r[26];
				wr_data_i    = w;
				wr_valid_i   = 1'b1;
				exp_q.push_back(w);
				credits--;
				sent++;
			end
		end

		// Let the queue empty.
		cts_n_i = 1'b0;
		while (finish_cnt < NUM_FRAMES && waited < DRAIN_CLKS) begin
			next_cycle();
			wr_valid_i = 1'b0;
			waited++;
		end
		repeat (2 * CPB) next_cycle();

		assert (frames_done == NUM_FRAMES) else begin
			$display("error data_order: frames expected %0d, actual %0d", NUM_FRAMES, frames_done);
			err_data++;
		end
		assert (credits == DEPTH) else begin
			$display("error credits: host credits expected %0d, actual %0d", DEPTH, credits);
			err_credit++;
		end
		assert (credit_pulses == NUM_FRAMES) else begin
			$display("error credits: pulses expected %0d, actual %0d", NUM_FRAMES, credit_pulses);
			err_credit++;
		end
		assert (finish_cnt == NUM_FRAMES) else begin
			$display("error finish_marking: pulses expected %0d, actual %0d",
				NUM_FRAMES, finish_cnt);
			err_finish++;
		end
		assert (holds > 0) else begin
			$display("no clear-to-send hold took place during the traffic");
			err_cts++;
		end

		report_test("reset_idle", err_reset);
		report_test("data_order", err_data);
		report_test("framing", err_framing);
		report_test("credits", err_credit);
		report_test("clear_to_send", err_cts);
		report_test("finish_marking", err_finish);
		$display("summary: 6 tests, %0d failed, %0d errors", tests_failed, errors_total);
		if (errors_total == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Samples every cycle of each frame and rebuilds it from the oldest written word.
	initial begin : line_monitor
		uart_frame_pkg::frame_word_t w;
		logic                        exp_bits[$];
		logic [DATA_BITS-1:0]        decoded;
		logic [DATA_BITS-1:0]        d;
		logic                        bad_val;
		int                          bad_bit;
		int                          i;
		int                          b;

		@(posedge reset_n);
		forever begin
			@(negedge clk);
			if (txd_o == 1'b0) begin
				assert (cyc - cts_low_cyc <= 2) else begin
					$display("start bit sent while cts_n_i was held high for %0d cycles",
						cyc - cts_low_cyc);
					err_cts++;
				end
				if (exp_q.size() == 0) begin
					$display("start bit on txd_o with no word written");
					err_data++;
					while (txd_o == 1'b0) begin
						@(negedge clk);
					end
				end else begin
					w = exp_q.pop_front();
					d = w.data;
					exp_bits.delete();
					exp_bits.push_back(1'b0);
					repeat (DATA_BITS) begin
						exp_bits.push_back(d[0]);
						d = d >> 1;
					end
					if (w.parity_en) begin
						exp_bits.push_back(^w.data ^ w.parity_odd);
					end
					exp_bits.push_back(1'b1);
					if (w.two_stop) begin
						exp_bits.push_back(1'b1);
					end
					decoded = '0;
					bad_bit = -1;
					bad_val = 1'b0;
					for (i = 0; i < exp_bits.size() * CPB; i++) begin
						if (i > 0) begin
							@(negedge clk);
						end
						b = i / CPB;
						// Data read at mid-bit, LSB first.
						if (b >= 1 && b <= DATA_BITS && i % CPB == CPB / 2) begin
							decoded = {txd_o, decoded[DATA_BITS-1:1]};
						end
						if (txd_o !== exp_bits[b] && bad_bit < 0) begin
							bad_bit = b;
							bad_val = txd_o;
						end
					end
					assert (decoded == w.data) else begin
						$display("error data_order: frame %0d expected 0x%02h, actual 0x%02h",
							frames_done, w.data, decoded);
						err_data++;
					end
					assert (bad_bit < 0) else begin
						$display("error framing: frame %0d bit %0d expected %b, actual %b",
							frames_done, bad_bit, exp_bits[bad_bit], bad_val);
						err_framing++;
					end
					frames_done++;
				end
			end
		end
	end

	initial begin : watchdog
		repeat (TIMEOUT_CLKS) @(posedge clk);
		$display("timeout: the run did not complete within %0d cycles", TIMEOUT_CLKS);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/uart_tx_top.sv
// UART transmit subsystem top; host writes frame words with credits, serial line comes out.
`default_nettype none

module uart_tx_top (
	input  logic                        clk,
	input  logic                        reset_n,
	input  logic                        tx_en_i,
	input  logic                        cts_n_i,
	input  logic                        wr_valid_i,
	input  uart_frame_pkg::frame_word_t wr_data_i,
	output logic                        credit_o,
	output logic                        txd_o,
	output logic                        tx_finish_o
);

	uart_frame_pkg::frame_word_t head_word;

	logic word_avail;
	logic pop;
	logic tick;
	logic tick_d;

	uart_tx_if tx_if ();

	tx_credit_fifo u_tx_credit_fifo (
		.clk          (clk),
		.reset_n      (reset_n),
		.wr_valid_i   (wr_valid_i),
		.wr_data_i    (wr_data_i),
		.pop_i        (pop),
		.word_avail_o (word_avail),
		.head_word_o  (head_word),
		.credit_o     (credit_o)
	);

	// Divider runs only during a frame and realigns at each load.
	baud_tick_gen u_baud_tick_gen (
		.clk       (clk),
		.reset_n   (reset_n),
		.run_i     (tx_if.trans_en),
		.restart_i (tx_if.load),
		.tick_o    (tick),
		.tick_d_o  (tick_d)
	);

	transmitter_controller u_transmitter_controller (
		.clk         (clk),
		.reset_n     (reset_n),
		.tx_en_i     (tx_en_i),
		.cts_n_i     (cts_n_i),
		.start_tx_i  (word_avail),
		.tick_d_i    (tick_d),
		.head_word_i (head_word),
		.pop_o       (pop),
		.tx_finish_o (tx_finish_o),
		.ctl         (tx_if.ctrl)
	);

	tx_shifter u_tx_shifter (
		.clk     (clk),
		.reset_n (reset_n),
		.tick_i  (tick),
		.sh      (tx_if.shift),
		.txd_o   (txd_o)
	);

endmodule

`default_nettype wire

// File: verilog/tx_shifter.sv
// Serial line driver; puts start, data, parity and stop bits of the loaded frame on txd.
`default_nettype none

module tx_shifter (
	input  logic     clk,
	input  logic     reset_n,
	input  logic     tick_i,
	uart_tx_if.shift sh,
	output logic     txd_o
);

	logic [uart_cfg_pkg::DATA_BITS-1:0] shift_q;
	logic [uart_cfg_pkg::BIT_CNT_W-1:0] data_cnt_q;
	logic                               parity_q;
	logic                               two_stop_q;
	logic                               stop_cnt_q;
	logic                               tick_q;
	logic                               in_data;
	logic                               in_stop;
	logic                               line_bit;

	assign in_data = (sh.state == uart_frame_pkg::TRANS_DATA);
	assign in_stop = (sh.state == uart_frame_pkg::TRANS_STOP);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			tick_q <= 1'b0;
		end else begin
			tick_q <= tick_i;
		end
	end

	// Running parity starts at the odd flag and folds in each bit as it leaves.
	always_ff @(posedge clk) begin
		if (sh.load) begin
			shift_q    <= sh.frame.data;
			parity_q   <= sh.frame.parity_odd;
			two_stop_q <= sh.frame.two_stop;
		end else if (in_data && tick_q) begin
			shift_q  <= shift_q >> 1;
			parity_q <= parity_q ^ shift_q[0];
		end
	end

	// Bit counters advance on tick, one cycle before the period ends.
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			data_cnt_q <= '0;
			stop_cnt_q <= 1'b0;
		end else if (sh.load) begin
			data_cnt_q <= '0;
			stop_cnt_q <= 1'b0;
		end else begin
			if (in_data && tick_i) begin
				data_cnt_q <= data_cnt_q + 1'b1;
			end
			if (in_stop && tick_i) begin
				stop_cnt_q <= ~stop_cnt_q;
			end
		end
	end

	// Done flags fall on the last cycle of the bit.
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			sh.trans_data_fi <= 1'b0;
			sh.trans_stop_fi <= 1'b0;
		end else begin
			sh.trans_data_fi <= tick_i & in_data &
				(data_cnt_q == uart_cfg_pkg::BIT_CNT_W'(uart_cfg_pkg::DATA_BITS - 1));
			sh.trans_stop_fi <= tick_i & in_stop & (stop_cnt_q == two_stop_q);
		end
	end

	always_comb begin
		case (sh.state)
			uart_frame_pkg::TRANS_START:  line_bit = 1'b0;
			uart_frame_pkg::TRANS_DATA:   line_bit = shift_q[0];
			uart_frame_pkg::TRANS_PARITY: line_bit = parity_q;
			default:                      line_bit = 1'b1;
		endcase
	end

	// Registered line, idle high.
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			txd_o <= 1'b1;
		end else begin
			txd_o <= line_bit;
		end
	end

endmodule

`default_nettype wire

// File: verilog/transmitter_controller.sv
// Frame sequencing FSM; waits for clear-to-send and a queued word, then steps through the frame.
`default_nettype none

module transmitter_controller (
	input  logic                        clk,
	input  logic                        reset_n,
	input  logic                        tx_en_i,
	input  logic                        cts_n_i,
	input  logic                        start_tx_i,
	input  logic                        tick_d_i,
	input  uart_frame_pkg::frame_word_t head_word_i,
	output logic                        pop_o,
	output logic                        tx_finish_o,
	uart_tx_if.ctrl                     ctl
);

	uart_frame_pkg::tx_state_t   state_q;
	uart_frame_pkg::tx_state_t   state_d;
	uart_frame_pkg::frame_word_t frame_q;

	logic start_d1_q;
	logic start_d2_q;
	logic cts_ok;
	logic begin_frame;
	logic begin_q;

	assign cts_ok = tx_en_i & ~cts_n_i;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state_q <= uart_frame_pkg::IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// Start strobe seen for two cycles before use.
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			start_d1_q <= 1'b0;
			start_d2_q <= 1'b0;
		end else begin
			start_d1_q <= start_tx_i;
			start_d2_q <= start_d1_q;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			uart_frame_pkg::IDLE:
				state_d = tx_en_i ? uart_frame_pkg::CTS : uart_frame_pkg::IDLE;
			uart_frame_pkg::CTS:
				state_d = !cts_n_i ? uart_frame_pkg::WAIT :
					!tx_en_i ? uart_frame_pkg::IDLE : uart_frame_pkg::CTS;
			uart_frame_pkg::WAIT:
				state_d = cts_n_i ? uart_frame_pkg::CTS :
					!tx_en_i ? uart_frame_pkg::IDLE :
					start_d2_q ? uart_frame_pkg::TRANS_START : uart_frame_pkg::WAIT;
			uart_frame_pkg::TRANS_START:
				state_d = tick_d_i ? uart_frame_pkg::TRANS_DATA : uart_frame_pkg::TRANS_START;
			uart_frame_pkg::TRANS_DATA:
				if (ctl.trans_data_fi) begin
					state_d = frame_q.parity_en ? uart_frame_pkg::TRANS_PARITY :
						uart_frame_pkg::TRANS_STOP;
				end
			uart_frame_pkg::TRANS_PARITY:
				state_d = tick_d_i ? uart_frame_pkg::TRANS_STOP : uart_frame_pkg::TRANS_PARITY;
			uart_frame_pkg::TRANS_STOP:
				state_d = ctl.trans_stop_fi ? uart_frame_pkg::FINISH : uart_frame_pkg::TRANS_STOP;
			uart_frame_pkg::FINISH:
				// Back to back frames skip WAIT.
				state_d = (cts_ok & start_d2_q) ? uart_frame_pkg::TRANS_START :
					cts_ok ? uart_frame_pkg::WAIT :
					tx_en_i ? uart_frame_pkg::CTS : uart_frame_pkg::IDLE;
			default:
				state_d = uart_frame_pkg::IDLE;
		endcase
	end

	assign begin_frame = (state_d == uart_frame_pkg::TRANS_START) &&
		(state_q != uart_frame_pkg::TRANS_START);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			begin_q <= 1'b0;
		end else begin
			begin_q <= begin_frame;
		end
	end

	// Word taken from the queue head as the frame begins.
	always_ff @(posedge clk) begin
		if (begin_frame) begin
			frame_q <= head_word_i;
		end
	end

	assign ctl.trans_en = state_q inside {uart_frame_pkg::TRANS_START,
		uart_frame_pkg::TRANS_DATA, uart_frame_pkg::TRANS_PARITY, uart_frame_pkg::TRANS_STOP};
	assign ctl.load  = begin_q;
	assign ctl.state = state_q;
	assign ctl.frame = frame_q;

	assign pop_o       = begin_q;
	assign tx_finish_o = (state_q == uart_frame_pkg::FINISH);

endmodule

`default_nettype wire

// File: verilog/tx_credit_fifo.sv
// Transmit word queue; the host spends a credit per write and gets one back per freed slot.
`default_nettype none

module tx_credit_fifo (
	input  logic                        clk,
	input  logic                        reset_n,
	input  logic                        wr_valid_i,
	input  uart_frame_pkg::frame_word_t wr_data_i,
	input  logic                        pop_i,
	output logic                        word_avail_o,
	output uart_frame_pkg::frame_word_t head_word_o,
	output logic                        credit_o
);

	uart_frame_pkg::frame_word_t mem [uart_cfg_pkg::FIFO_DEPTH];

	logic [uart_cfg_pkg::FIFO_AW-1:0]    wr_ptr_q;
	logic [uart_cfg_pkg::FIFO_AW-1:0]    rd_ptr_q;
	logic [uart_cfg_pkg::FIFO_CNT_W-1:0] count_q;
	logic                                full;
	logic                                do_wr;
	logic                                do_pop;

	assign full = (count_q == uart_cfg_pkg::FIFO_CNT_W'(uart_cfg_pkg::FIFO_DEPTH));

	// Writes without credit find the queue full and are lost.
	assign do_wr  = wr_valid_i & ~full;
	assign do_pop = pop_i & word_avail_o;

	assign word_avail_o = (count_q != '0);
	assign head_word_o  = mem[rd_ptr_q];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr_q] <= wr_data_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({do_wr, do_pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// One credit back, the cycle after each pop.
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			credit_o <= 1'b0;
		end else begin
			credit_o <= do_pop;
		end
	end

endmodule

`default_nettype wire

// File: verilog/baud_tick_gen.sv
// Bit period divider; gives a tick per period while a frame runs, plus a delayed copy.
`default_nettype none

module baud_tick_gen (
	input  logic clk,
	input  logic reset_n,
	input  logic run_i,
	input  logic restart_i,
	output logic tick_o,
	output logic tick_d_o
);

	logic [uart_cfg_pkg::TICK_W-1:0] cnt_q;

	// Count runs down from CLKS_PER_BIT-1 to 0 once per bit.
	// The load cycle stands in for the first count.
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			cnt_q <= '0;
		end else if (!run_i) begin
			cnt_q <= '0;
		end else if (restart_i) begin
			cnt_q <= uart_cfg_pkg::TICK_W'(uart_cfg_pkg::CLKS_PER_BIT - 2);
		end else if (cnt_q == '0) begin
			cnt_q <= uart_cfg_pkg::TICK_W'(uart_cfg_pkg::CLKS_PER_BIT - 1);
		end else begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// Tick one cycle early so the delayed copy lands on the bit's last cycle.
	assign tick_o = run_i & (cnt_q == uart_cfg_pkg::TICK_W'(1));

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			tick_d_o <= 1'b0;
		end else begin
			tick_d_o <= tick_o;
		end
	end

endmodule

`default_nettype wire

// File: verilog/uart_tx_if.sv
// Control and status bundle between the frame FSM and the bit shifter, one per transmitter.
`default_nettype none

interface uart_tx_if;

	// High from TRANS_START through TRANS_STOP.
	logic trans_en;
	// One cycle at the start of each frame.
	logic load;
	uart_frame_pkg::tx_state_t state;
	uart_frame_pkg::frame_word_t frame;

	// Raised in the last cycle of the last data bit.
	logic trans_data_fi;
	// Raised in the last cycle of the last stop bit.
	logic trans_stop_fi;

	modport ctrl (
		output trans_en,
		output load,
		output state,
		output frame,
		input  trans_data_fi,
		input  trans_stop_fi
	);

	modport shift (
		input  load,
		input  state,
		input  frame,
		output trans_data_fi,
		output trans_stop_fi
	);

endinterface

`default_nettype wire

// File: verilog/uart_frame_pkg.sv
// Frame word layout and transmit FSM state encoding used across the UART transmitter.
`default_nettype none

package uart_frame_pkg;

	// One queued frame: the byte plus its framing options.
	typedef struct packed {
		logic                                two_stop;
		logic                                parity_odd;
		logic                                parity_en;
		logic [uart_cfg_pkg::DATA_BITS-1:0]  data;
	} frame_word_t;

	// Transmit FSM states.
	typedef enum logic [2:0] {
		IDLE,
		CTS,
		WAIT,
		TRANS_START,
		TRANS_DATA,
		TRANS_PARITY,
		TRANS_STOP,
		FINISH
	} tx_state_t;

endpackage

`default_nettype wire

// File: verilog/uart_cfg_pkg.sv
// Line timing and queue sizing constants shared by the UART transmitter RTL and its testbench.
`default_nettype none

package uart_cfg_pkg;

	// Data bits per frame, sent LSB first.
	localparam int DATA_BITS = 8;

	// Width of the data bit counter in the shifter.
	localparam int BIT_CNT_W = $clog2(DATA_BITS);

	// Clock cycles per bit period. Kept small so simulations stay short.
	localparam int CLKS_PER_BIT = 16;

	// Width of the baud divider count.
	localparam int TICK_W = $clog2(CLKS_PER_BIT);

	// Queue slots, equal to the credits a host starts with.
	localparam int FIFO_DEPTH = 4;

	// Queue pointer width.
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);

	// Occupancy counter width, one bit more to hold a full count.
	localparam int FIFO_CNT_W = FIFO_AW + 1;

endpackage

`default_nettype wire
